// File: cn_lut_dec.f
design/cn_lut_pkg.sv
design/sym_cn_lut.sv
design/cn_lut_cfg.sv
design/cn_node_update.sv
design/cn_lut_top.sv
bench/cn_lut_properties.sv
bench/cn_lut_tb.sv

// File: bench/cn_lut_tb.sv
module cn_lut_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import cn_lut_pkg::*;

   localparam int TIMEOUT = 16;                 // Cycle limit for every wait

   logic        write_clk;
   logic        rst_n;
   logic        cfg_wr;
   logic        cfg_rd;
   logic        cfg_sym;
   msg_t        cfg_addr_a;
   msg_t        cfg_addr_b;
   msg_t        cfg_data;
   logic        cfg_busy;
   logic        cfg_rvalid;
   msg_t        cfg_rdata;
   logic        in_valid;
   msg_t        v0;
   msg_t        v1;
   msg_t        v2;
   logic        out_valid;
   msg_t        c0;
   msg_t        c1;
   msg_t        c2;

   msg_t        model [LUT_DEPTH];              // What the table should hold
   msg_t        exp_c0 [$];                     // Expected results in issue order
   msg_t        exp_c1 [$];
   msg_t        exp_c2 [$];
   logic [31:0] rng;
   int          errors;

   cn_lut_top #(.WRITE_MIRROR(1'b1)) i_cn_lut_top (.*);

   initial begin
      write_clk = 1'b0;
      forever #20 write_clk = ~write_clk;       // 40 ns period
   end

   // Low bits of each xorshift32 step form a message
   function automatic msg_t rand_msg();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng[MSG_W-1:0];
   endfunction

   function automatic msg_t lut_ref(msg_t a, msg_t b);
      return model[{a, b}];                     // L(a,b)
   endfunction

   task automatic check_msg(string name, msg_t expected, msg_t actual);
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_valid(string name, logic expected, logic actual);
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_count(string name, int expected, int actual);
      if (actual != expected) begin
         errors++;
         $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      end
   endtask

   // Table write with the mirror applied to the model when allowed
   task automatic host_write(msg_t a, msg_t b, msg_t d, logic sym);
      int cycles;
      @(negedge write_clk);
      cfg_wr     = 1'b1;
      cfg_sym    = sym;
      cfg_addr_a = a;
      cfg_addr_b = b;
      cfg_data   = d;
      @(negedge write_clk);
      cfg_wr = 1'b0;
      cycles = 0;
      while (cfg_busy && cycles < TIMEOUT) begin
         @(negedge write_clk);
         cycles++;                              // Busy cycles seen
      end
      if (cfg_busy) begin
         errors++;
         $display("Timeout waiting for cfg_busy to fall after a write");
      end
      model[{a, b}] = d;
      if (sym && a != b)
         model[{b, a}] = d;
      check_count("cfg_busy cycles", (sym && a != b) ? 2 : 1, cycles);
   endtask

   task automatic host_read(msg_t a, msg_t b);
      int cycles;
      @(negedge write_clk);
      cfg_rd     = 1'b1;
      cfg_addr_a = a;
      cfg_addr_b = b;
      @(negedge write_clk);
      cfg_rd = 1'b0;
      cycles = 1;
      while (!cfg_rvalid && cycles < TIMEOUT) begin
         @(negedge write_clk);
         cycles++;
      end
      if (!cfg_rvalid) begin
         errors++;
         $display("Timeout waiting for cfg_rvalid after a read");
      end else begin
         check_count("cfg_rvalid latency", 2, cycles);
         check_msg("cfg_rdata", model[{a, b}], cfg_rdata);
      end
   endtask

   // One isolated update with its latency measured
   task automatic node_single();
      int   cycles;
      msg_t m0;
      msg_t m1;
      msg_t m2;
      m0 = rand_msg();
      m1 = rand_msg();
      m2 = rand_msg();
      @(negedge write_clk);
      in_valid = 1'b1;
      v0       = m0;
      v1       = m1;
      v2       = m2;
      @(negedge write_clk);
      in_valid = 1'b0;
      cycles   = 1;
      while (!out_valid && cycles < TIMEOUT) begin
         @(negedge write_clk);
         cycles++;
      end
      if (!out_valid) begin
         errors++;
         $display("Timeout waiting for out_valid after a single update");
      end else begin
         check_count("out_valid latency", 2, cycles);
         check_msg("c0", lut_ref(m1, m2), c0);
         check_msg("c1", lut_ref(m0, m2), c1);
         check_msg("c2", lut_ref(m0, m1), c2);
      end
   endtask

   task automatic stream_drive(int count);
      msg_t m0;
      msg_t m1;
      msg_t m2;
      for (int i = 0; i < count; i++) begin
         m0 = rand_msg();
         m1 = rand_msg();
         m2 = rand_msg();
         @(negedge write_clk);
         in_valid = 1'b1;                       // Held high for one update per cycle
         v0       = m0;
         v1       = m1;
         v2       = m2;
         exp_c0.push_back(lut_ref(m1, m2));
         exp_c1.push_back(lut_ref(m0, m2));
         exp_c2.push_back(lut_ref(m0, m1));
      end
      @(negedge write_clk);
      in_valid = 1'b0;
   endtask

   // Results must arrive in order on consecutive cycles
   task automatic stream_collect(int count);
      int cycles;
      @(negedge write_clk);                     // Skip any earlier result
      cycles = 0;
      while (!out_valid && cycles < TIMEOUT) begin
         @(negedge write_clk);
         cycles++;
      end
      if (!out_valid) begin
         errors++;
         $display("Timeout waiting for out_valid in a stream");
      end else begin
         for (int i = 0; i < count; i++) begin
            if (i > 0)
               @(negedge write_clk);
            check_valid("out_valid", 1'b1, out_valid);
            check_msg("c0", exp_c0.pop_front(), c0);
            check_msg("c1", exp_c1.pop_front(), c1);
            check_msg("c2", exp_c2.pop_front(), c2);
         end
      end
   endtask

   initial begin
      lut_addr_t addr;
      msg_t      a;
      msg_t      b;
      int        sva_fails;
      errors     = 0;
      rng        = 32'h1aed;
      rst_n      = 1'b0;
      cfg_wr     = 1'b0;
      cfg_rd     = 1'b0;
      cfg_sym    = 1'b0;
      cfg_addr_a = '0;
      cfg_addr_b = '0;
      cfg_data   = '0;
      in_valid   = 1'b0;
      v0         = '0;
      v1         = '0;
      v2         = '0;
      repeat (10) @(negedge write_clk);
      rst_n = 1'b1;
      check_valid("cfg_busy", 1'b0, cfg_busy);
      check_valid("cfg_rvalid", 1'b0, cfg_rvalid);
      check_valid("out_valid", 1'b0, out_valid);

      // Plain writes over the whole table followed by read-back
      for (int i = 0; i < LUT_DEPTH; i++) begin
         addr = lut_addr_t'(i);
         host_write(addr[5:3], addr[2:0], rand_msg(), 1'b0);
      end
      for (int i = 0; i < LUT_DEPTH; i++) begin
         addr = lut_addr_t'(i);
         host_read(addr[5:3], addr[2:0]);
      end

      // Mirrored writes with every fourth one on the diagonal
      for (int i = 0; i < 12; i++) begin
         a = rand_msg();
         b = (i % 4 == 0) ? a : rand_msg();
         host_write(a, b, rand_msg(), 1'b1);
         host_read(a, b);
         host_read(b, a);
      end

      repeat (20) node_single();

      fork
         stream_drive(24);
         stream_collect(24);
      join

      // Port D read-back alongside a stream on ports A to C
      fork
         stream_drive(20);
         stream_collect(20);
         for (int i = 0; i < 4; i++) begin
            addr = lut_addr_t'(i * 21 + 5);
            host_read(addr[5:3], addr[2:0]);
         end
      join

      repeat (2) @(negedge write_clk);
      sva_fails = i_cn_lut_top.i_cn_lut_properties.fails;   // Bound assertion failures
      $display("Errors: %0d checks, %0d assertions", errors, sva_fails);
      if (errors == 0 && sva_fails == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule : cn_lut_tb

// File: bench/cn_lut_properties.sv
module cn_lut_properties (
   input logic write_clk,
   input logic rst_n,
   input logic cfg_wr,
   input logic cfg_rd,
   input logic cfg_busy,
   input logic cfg_rvalid,
   input logic in_valid,
   input logic out_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   int fails;                                   // Assertion failures so far

   initial fails = 0;

   // Node updates stay off the table while it is being written
   update_idle: assert property (@(posedge write_clk) disable iff (!rst_n)
      in_valid |-> !cfg_busy)
      else begin
         fails++;
         $error("in_valid pulsed while cfg_busy is high");
      end

   // Host strobes only in the idle state
   host_idle: assert property (@(posedge write_clk) disable iff (!rst_n)
      (cfg_wr || cfg_rd) |-> !cfg_busy)
      else begin
         fails++;
         $error("cfg_wr or cfg_rd pulsed while cfg_busy is high");
      end

   rvalid_latency: assert property (@(posedge write_clk) disable iff (!rst_n)
      cfg_rvalid == $past(cfg_rd, 2))          // Address stage, then capture
      else begin
         fails++;
         $error("cfg_rvalid not two cycles after cfg_rd");
      end

   out_latency: assert property (@(posedge write_clk) disable iff (!rst_n)
      out_valid == $past(in_valid, 2))         // Input stage, then result stage
      else begin
         fails++;
         $error("out_valid not two cycles after in_valid");
      end

endmodule : cn_lut_properties

bind cn_lut_top cn_lut_properties i_cn_lut_properties (
   .write_clk  (write_clk),
   .rst_n      (rst_n),
   .cfg_wr     (cfg_wr),
   .cfg_rd     (cfg_rd),
   .cfg_busy   (cfg_busy),
   .cfg_rvalid (cfg_rvalid),
   .in_valid   (in_valid),
   .out_valid  (out_valid)
);

// File: design/cn_lut_top.sv
module cn_lut_top #(
   parameter bit WRITE_MIRROR = 1'b1
) (
   input  logic                  write_clk,
   input  logic                  rst_n,

   // Host configuration
   input  logic                  cfg_wr,
   input  logic                  cfg_rd,
   input  logic                  cfg_sym,
   input  cn_lut_pkg::msg_t      cfg_addr_a,
   input  cn_lut_pkg::msg_t      cfg_addr_b,
   input  cn_lut_pkg::msg_t      cfg_data,
   output logic                  cfg_busy,
   output logic                  cfg_rvalid,
   output cn_lut_pkg::msg_t      cfg_rdata,

   // Check node messages
   input  logic                  in_valid,
   input  cn_lut_pkg::msg_t      v0,
   input  cn_lut_pkg::msg_t      v1,
   input  cn_lut_pkg::msg_t      v2,
   output logic                  out_valid,
   output cn_lut_pkg::msg_t      c0,
   output cn_lut_pkg::msg_t      c1,
   output cn_lut_pkg::msg_t      c2
);

   import cn_lut_pkg::*;

   // Configuration to table
   logic      lut_we;
   lut_addr_t lut_waddr;
   lut_addr_t lut_raddr;
   msg_t      lut_wdata;
   msg_t      lut_rdata;                        // Port D back to the host

   // Node update to table
   lut_addr_t addr0;
   lut_addr_t addr1;
   lut_addr_t addr2;
   msg_t      lut_d0;
   msg_t      lut_d1;
   msg_t      lut_d2;

   cn_lut_cfg #(
      .WRITE_MIRROR (WRITE_MIRROR)
   ) i_cn_lut_cfg (
      .write_clk  (write_clk),
      .rst_n      (rst_n),
      .cfg_wr     (cfg_wr),
      .cfg_rd     (cfg_rd),
      .cfg_sym    (cfg_sym),
      .cfg_addr_a (cfg_addr_a),
      .cfg_addr_b (cfg_addr_b),
      .cfg_data   (cfg_data),
      .cfg_busy   (cfg_busy),
      .cfg_rvalid (cfg_rvalid),
      .cfg_rdata  (cfg_rdata),
      .lut_rdata  (lut_rdata),
      .lut_we     (lut_we),
      .lut_waddr  (lut_waddr),
      .lut_raddr  (lut_raddr),
      .lut_wdata  (lut_wdata)
   );

   // Table store
   sym_cn_lut i_sym_cn_lut (
      .lut_data0  (lut_d0),
      .lut_data1  (lut_d1),
      .lut_data2  (lut_d2),
      .lut_data3  (lut_rdata),
      .lut_in     (lut_wdata),
      .write_addr (lut_waddr),
      .read_addr0 (addr0),
      .read_addr1 (addr1),
      .read_addr2 (addr2),
      .read_addr3 (lut_raddr),
      .we         (lut_we),
      .write_clk  (write_clk)
   );

   cn_node_update i_cn_node_update (
      .write_clk (write_clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .v0        (v0),
      .v1        (v1),
      .v2        (v2),
      .addr0     (addr0),
      .addr1     (addr1),
      .addr2     (addr2),
      .lut_d0    (lut_d0),
      .lut_d1    (lut_d1),
      .lut_d2    (lut_d2),
      .out_valid (out_valid),
      .c0        (c0),
      .c1        (c1),
      .c2        (c2)
   );

endmodule : cn_lut_top

// File: design/cn_node_update.sv
module cn_node_update (
   input  logic                  write_clk,
   input  logic                  rst_n,

   // Incoming variable-to-check messages
   input  logic                  in_valid,
   input  cn_lut_pkg::msg_t      v0,
   input  cn_lut_pkg::msg_t      v1,
   input  cn_lut_pkg::msg_t      v2,

   // Table lookups
   output cn_lut_pkg::lut_addr_t addr0,         // To read port A
   output cn_lut_pkg::lut_addr_t addr1,         // To read port B
   output cn_lut_pkg::lut_addr_t addr2,         // To read port C
   input  cn_lut_pkg::msg_t      lut_d0,
   input  cn_lut_pkg::msg_t      lut_d1,
   input  cn_lut_pkg::msg_t      lut_d2,

   // Extrinsic check-to-variable messages
   output logic                  out_valid,
   output cn_lut_pkg::msg_t      c0,
   output cn_lut_pkg::msg_t      c1,
   output cn_lut_pkg::msg_t      c2
);

   import cn_lut_pkg::*;

   logic vld_q;                                 // Stage 1 valid

   // Stage 1 messages
   msg_t v0_q;
   msg_t v1_q;
   msg_t v2_q;

   // Stage 1 payload
   // Loaded only on an accepted update
   always_ff @(posedge write_clk) begin
      if (in_valid) begin
         v0_q <= v0;
         v1_q <= v1;
         v2_q <= v2;
      end
   end

   // Extrinsic addressing
   // Each edge looks up the pair of the other two messages
   assign addr0 = {v1_q, v2_q};                 // c0 = L(v1,v2)
   assign addr1 = {v0_q, v2_q};                 // c1 = L(v0,v2)
   assign addr2 = {v0_q, v1_q};                 // c2 = L(v0,v1)

   // Stage 2 payload
   // Asynchronous table data captured one edge later
   always_ff @(posedge write_clk) begin
      if (vld_q) begin
         c0 <= lut_d0;
         c1 <= lut_d1;
         c2 <= lut_d2;
      end
   end

   // Valid pipeline
   // A new update may enter every cycle
   always_ff @(posedge write_clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q     <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         vld_q     <= in_valid;
         out_valid <= vld_q;                       // Two edges after in_valid
      end
   end

endmodule : cn_node_update

// File: design/cn_lut_cfg.sv
module cn_lut_cfg #(
   parameter bit WRITE_MIRROR = 1'b1            // Allow the {b,a} mirror write
) (
   input  logic                  write_clk,
   input  logic                  rst_n,

   // Host side
   input  logic                  cfg_wr,        // Write strobe
   input  logic                  cfg_rd,        // Read-back strobe
   input  logic                  cfg_sym,       // Request a mirrored write
   input  cn_lut_pkg::msg_t      cfg_addr_a,
   input  cn_lut_pkg::msg_t      cfg_addr_b,
   input  cn_lut_pkg::msg_t      cfg_data,
   output logic                  cfg_busy,
   output logic                  cfg_rvalid,
   output cn_lut_pkg::msg_t      cfg_rdata,

   // Table side
   input  cn_lut_pkg::msg_t      lut_rdata,     // Port D data
   output logic                  lut_we,
   output cn_lut_pkg::lut_addr_t lut_waddr,
   output cn_lut_pkg::lut_addr_t lut_raddr,
   output cn_lut_pkg::msg_t      lut_wdata
);

   import cn_lut_pkg::*;

   // Write sequencer states
   typedef enum logic [1:0] {
      ST_IDLE,                                  // Ready for a host strobe
      ST_WR1,                                   // Writing {a,b}
      ST_WR2                                    // Writing {b,a}
   } wr_state_t;

   wr_state_t state;
   logic      mirror_q;                         // Second write pending
   lut_addr_t waddr_q;
   msg_t      wdata_q;
   logic      rd_q;                             // Read-back in the address stage
   lut_addr_t raddr_q;

   // Write sequencer
   always_ff @(posedge write_clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= ST_IDLE;
         mirror_q <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (cfg_wr) begin
                  state    <= ST_WR1;
                  // No mirror for diagonal entries
                  mirror_q <= WRITE_MIRROR && cfg_sym && (cfg_addr_a != cfg_addr_b);
               end
            end
            ST_WR1: begin
               state <= mirror_q ? ST_WR2 : ST_IDLE;
            end
            default: begin
               state    <= ST_IDLE;                // Mirror write done
               mirror_q <= 1'b0;
            end
         endcase
      end
   end

   // Write address and data
   always_ff @(posedge write_clk) begin
      if (state == ST_IDLE && cfg_wr) begin
         waddr_q <= {cfg_addr_a, cfg_addr_b};
         wdata_q <= cfg_data;                      // Held for both writes
      end else if (state == ST_WR1 && mirror_q) begin
         waddr_q <= {waddr_q[MSG_W-1:0], waddr_q[ADDR_W-1:MSG_W]};   // Swap halves
      end
   end

   assign lut_we    = (state != ST_IDLE);
   assign lut_waddr = waddr_q;
   assign lut_wdata = wdata_q;
   assign cfg_busy  = (state != ST_IDLE);       // One or two cycles per write

   // Read-back pipeline
   // Address stage first, then capture of port D
   always_ff @(posedge write_clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_q       <= 1'b0;
         cfg_rvalid <= 1'b0;
      end else begin
         rd_q       <= cfg_rd;
         cfg_rvalid <= rd_q;                       // Two edges after the strobe
      end
   end

   always_ff @(posedge write_clk) begin
      if (cfg_rd) begin
         raddr_q <= {cfg_addr_a, cfg_addr_b};
      end
      if (rd_q) begin
         cfg_rdata <= lut_rdata;                   // Port D settled on raddr_q
      end
   end

   assign lut_raddr = raddr_q;

endmodule : cn_lut_cfg

// File: design/sym_cn_lut.sv
module sym_cn_lut (
   output cn_lut_pkg::msg_t      lut_data0,     // Read port A data
   output cn_lut_pkg::msg_t      lut_data1,     // Read port B data
   output cn_lut_pkg::msg_t      lut_data2,     // Read port C data
   output cn_lut_pkg::msg_t      lut_data3,     // Shared port D data

   input  cn_lut_pkg::msg_t      lut_in,        // Write data
   input  cn_lut_pkg::lut_addr_t write_addr,    // Write address on port D

   input  cn_lut_pkg::lut_addr_t read_addr0,
   input  cn_lut_pkg::lut_addr_t read_addr1,
   input  cn_lut_pkg::lut_addr_t read_addr2,
   input  cn_lut_pkg::lut_addr_t read_addr3,    // Read-back address on port D

   input  logic                  we,
   input  logic                  write_clk
);

   import cn_lut_pkg::*;

   // Table store
   // Maps onto distributed RAM with one write port and four read ports
   msg_t      lut_mem [LUT_DEPTH];

   lut_addr_t syn_addr;                         // Port D address after the mux

   // Port D shares its address between the write and the read-back
   assign syn_addr = we ? write_addr : read_addr3;

   // Synchronous write through port D
   always_ff @(posedge write_clk) begin
      if (we) begin
         lut_mem[syn_addr] <= lut_in;
      end
   end

   // Node update reads
   // Fully asynchronous and independent of port D
   assign lut_data0 = lut_mem[read_addr0];      // Edge 0 lookup
   assign lut_data1 = lut_mem[read_addr1];      // Edge 1 lookup
   assign lut_data2 = lut_mem[read_addr2];      // Edge 2 lookup

   // Port D read
   // Shows the entry under the write address while we is high
   // Only meaningful to the host while we is low
   assign lut_data3 = lut_mem[syn_addr];

endmodule : sym_cn_lut

// File: design/cn_lut_pkg.sv
package cn_lut_pkg;

   // Message quantization
   localparam int MSG_W = 3;                    // Bits per check/variable message

   // Table geometry
   localparam int ADDR_W = 2 * MSG_W;           // One message per address half
   localparam int LUT_DEPTH = 1 << ADDR_W;      // 64 entries

   // Quantized message
   // Same width on the variable side and the check side
   typedef logic [MSG_W-1:0] msg_t;

   // Table address
   // First message in the upper half, second message in the lower half
   typedef logic [ADDR_W-1:0] lut_addr_t;

endpackage : cn_lut_pkg
